// File: instructionProcessor.f
design/procPkg.sv
design/regPortIf.sv
design/aluUnit.sv
design/instrDecoder.sv
design/regFile.sv
design/dataRam.sv
design/instructionProcessor.sv
tests/instructionProcessorTb.sv

// File: tests/instructionProcessorTb.sv
// Testbench for the instruction processor with directed tests and a register, flag and RAM model
`timescale 1ns/1ns
`default_nettype none

module instructionProcessorTb import procPkg::*;;
    logic        clock;
    logic        arstN;
    instrWord    instr;
    logic        regLoad;
    regSel       regChoose;
    logic [15:0] regData;
    regSel       dbgSel;
    logic [15:0] dbgData;
    flagVec      flags;
    coreInstr    instructionOut;

    logic [15:0] mRegs [8];
    logic [15:0] mRam [256];
    flagVec      mFlags;
    coreInstr    mOut;
    int          errors;
    logic [31:0] rndState;
    instrWord    idleWord;

    instructionProcessor dut_i (
        .clock          (clock),
        .arstN          (arstN),
        .instr          (instr),
        .regLoad        (regLoad),
        .regChoose      (regChoose),
        .regData        (regData),
        .dbgSel         (dbgSel),
        .dbgData        (dbgData),
        .flags          (flags),
        .instructionOut (instructionOut)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] randomWord();
        rndState = xorshift32(rndState);
        return rndState[23:8];
    endfunction

    function automatic instrWord encode(input logic alu, input aluOp op, input condCode cc,
                                        input regSel dst, input regSel src);
        return {src, dst, cc, op, alu, 1'b0};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got=%h expected=%h", name, got, exp);
            errors++;
        end
    endtask

    // Returns {flags, result}
    function automatic logic [19:0] modelAlu(input aluOp op, input logic [15:0] a,
                                             input logic [15:0] b, input logic cin);
        logic [15:0] res;
        logic        c;
        logic        v;
        int          wide;
        int          sa;
        int          sb;
        int          carryTerm;
        flagVec      f;
        c = 1'b0;
        v = 1'b0;
        sa = $signed(a);
        sb = $signed(b);
        carryTerm = (op == opAdc || op == opSbc) ? int'(cin) : 0;
        case (op)
            opAdd, opAdc: begin
                wide = int'(a) + int'(b) + carryTerm;
                res = wide[15:0];
                c = wide > 65535;
                v = (sa + sb + carryTerm > 32767) || (sa + sb + carryTerm < -32768);
            end
            opSub, opSbc: begin
                wide = int'(a) - int'(b) - carryTerm;
                res = wide[15:0];
                c = wide < 0;                    // Borrow
                v = (sa - sb - carryTerm > 32767) || (sa - sb - carryTerm < -32768);
            end
            opAnd: res = a & b;
            opOr:  res = a | b;
            opXor: res = a ^ b;
            opNot: res = ~a;
            opShl: begin
                res = a << 1;
                c = a[15];
            end
            opShr: begin
                res = a >> 1;
                c = a[0];
            end
            opSar: begin
                res = $signed(a) >>> 1;
                c = a[0];
            end
            default: res = b;
        endcase
        f[flagCarry]    = c;
        f[flagSign]     = res[15];
        f[flagOverflow] = v;
        f[flagZero]     = (res == 16'h0000);
        return {f, res};
    endfunction

    function automatic logic conditionHolds(input condCode cc, input flagVec f);
        logic z;
        logic s;
        logic v;
        logic c;
        z = f[flagZero];
        s = f[flagSign];
        v = f[flagOverflow];
        c = f[flagCarry];
        case (cc)
            condEq: return z;
            condNe: return !z;
            condGt: return !z && (s == v);
            condLt: return s != v;
            condGe: return s == v;
            condLe: return z || (s != v);
            condCs: return c;
            condCc: return !c;
            condMi: return s;
            condPl: return !s;
            condAl: return 1'b1;
            condVs: return v;
            condVc: return !v;
            condHi: return !c && !z;
            condLs: return c || z;
            default: return 1'b0;               // nv
        endcase
    endfunction

    task automatic modelStep(input instrWord word);
        aluOp        op;
        regSel       dst;
        regSel       src;
        logic [19:0] aluOut;
        logic        writeBack;
        logic [15:0] wbValue;
        op = word[5:2];
        dst = word[12:10];
        src = word[15:13];
        writeBack = 1'b0;
        wbValue = 16'h0000;
        if (word[0]) begin
            mOut = word[15:1];
        end else begin
            mOut = idleWord[15:1];
            if (conditionHolds(condCode'(word[9:6]), mFlags)) begin
                if (word[1]) begin
                    aluOut = modelAlu(op, mRegs[dst], mRegs[src], mFlags[flagCarry]);
                    writeBack = 1'b1;
                    wbValue = aluOut[15:0];
                    mFlags = aluOut[19:16];
                end else if (op == memLoad) begin
                    writeBack = 1'b1;
                    wbValue = mRam[mRegs[src][7:0]];
                end else if (op == memStore) begin
                    mRam[mRegs[src][7:0]] = mRegs[dst];
                end else if (op == memMove) begin
                    writeBack = 1'b1;
                    wbValue = mRegs[src];
                end
            end
        end
        mRegs[7] = mRegs[7] + 16'd1;
        if (writeBack) begin
            mRegs[dst] = wbValue;               // Overrides the ip step
        end
    endtask

    task automatic runInstr(input instrWord word);
        regLoad = 1'b0;
        instr = word;
        @(posedge clock);
        modelStep(word);
        @(negedge clock);
    endtask

    task automatic loadReg(input regSel sel, input logic [15:0] value);
        regLoad = 1'b1;
        regChoose = sel;
        regData = value;
        instr = randomWord();                   // Must be ignored
        @(posedge clock);
        mRegs[sel] = value;
        @(negedge clock);
        regLoad = 1'b0;
    endtask

    task automatic checkState();
        for (int i = 0; i < 8; i++) begin
            dbgSel = regSel'(i);
            #1;
            compareValue($sformatf("dbgData r%0d", i), dbgData, mRegs[i]);
        end
        compareValue("flags", flags, mFlags);
        compareValue("instructionOut", instructionOut, mOut);
    endtask

    task automatic resetAndLoad();
        checkState();
        for (int i = 0; i < 8; i++) begin
            loadReg(regSel'((i + 7) % 8), randomWord());    // ip first
        end
        checkState();
    endtask

    task automatic aluOperations();
        for (int k = 0; k < 22; k++) begin
            loadReg(3'd1, randomWord());
            loadReg(3'd2, randomWord());
            runInstr(encode(1'b1, aluOp'(k % 11), condAl, 3'd1, 3'd2));
            checkState();
        end
    endtask

    task automatic conditionalExec();
        logic [15:0] a;
        logic [15:0] ipBefore;
        for (int round = 0; round < 2; round++) begin
            for (int cc = 0; cc < 16; cc++) begin
                a = randomWord();
                loadReg(3'd3, a);
                loadReg(3'd4, (cc % 3 == 0) ? a : randomWord());
                loadReg(3'd5, randomWord());
                runInstr(encode(1'b1, (round == 0) ? opSub : opAdd, condAl, 3'd3, 3'd4));
                ipBefore = mRegs[7];
                runInstr(encode(1'b1, opXor, condCode'(cc), 3'd5, 3'd4));
                dbgSel = 3'd7;
                #1;
                compareValue("ip step", dbgData, ipBefore + 16'd1);
                checkState();
            end
        end
    endtask

    task automatic memoryAccess();
        logic [15:0] addrs [4];
        for (int k = 0; k < 4; k++) begin
            addrs[k] = randomWord();
            loadReg(3'd1, addrs[k]);
            loadReg(3'd2, randomWord());
            runInstr(encode(1'b0, memStore, condAl, 3'd2, 3'd1));
        end
        for (int k = 0; k < 4; k++) begin
            loadReg(3'd0, addrs[k]);
            runInstr(encode(1'b0, memLoad, condAl, regSel'(k + 1), 3'd0));
            checkState();
        end
        runInstr(encode(1'b0, memMove, condAl, 3'd5, 3'd1));
        checkState();
        // Store that must not happen, then read the address back
        loadReg(3'd0, addrs[0]);
        loadReg(3'd5, randomWord());
        runInstr(encode(1'b0, memStore, condNv, 3'd5, 3'd0));
        runInstr(encode(1'b0, memLoad, condAl, 3'd4, 3'd0));
        checkState();
    endtask

    task automatic coreForwarding();
        for (int k = 0; k < 4; k++) begin
            runInstr(randomWord() | 16'h0001);
            checkState();
            runInstr(idleWord);
            checkState();
        end
    endtask

    task automatic ipAsDestination();
        logic [15:0] target;
        target = randomWord();
        loadReg(3'd2, target);
        runInstr(encode(1'b0, memMove, condAl, 3'd7, 3'd2));
        dbgSel = 3'd7;
        #1;
        compareValue("ip after move", dbgData, target);
        repeat (3) runInstr(idleWord);
        dbgSel = 3'd7;
        #1;
        compareValue("ip counting", dbgData, target + 16'd3);
        checkState();
    endtask

    initial begin
        clock = 1'b0;
        arstN = 1'b0;
        idleWord = encode(1'b1, opAdd, condNv, 3'd0, 3'd0);     // addnv r0,r0
        instr = idleWord;
        regLoad = 1'b0;
        regChoose = 3'd0;
        regData = 16'h0000;
        dbgSel = 3'd0;
        errors = 0;
        rndState = 32'h3017;
        for (int i = 0; i < 8; i++) begin
            mRegs[i] = 16'h0000;
        end
        mFlags = 4'h0;
        mOut = idleWord[15:1];
        repeat (8) @(posedge clock);
        @(negedge clock);
        arstN = 1'b1;

        resetAndLoad();
        aluOperations();
        conditionalExec();
        memoryAccess();
        coreForwarding();
        ipAsDestination();

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/instructionProcessor.sv
// Instruction processor top: decoder, ALU, register file and data RAM on plain ports
`timescale 1ns/1ns
`default_nettype none

module instructionProcessor import procPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int ramAddrWidth = 8
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  instrWord             instr,
    input  logic                 regLoad,
    input  regSel                regChoose,
    input  logic [dataWidth-1:0] regData,
    input  regSel                dbgSel,
    output logic [dataWidth-1:0] dbgData,
    output flagVec               flags,
    output coreInstr             instructionOut
);
    logic [dataWidth-1:0]    aluA;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    aluResult;
    aluOp                    aluOpSel;
    logic                    aluCarryIn;
    logic                    aluCarry;
    logic                    aluSign;
    logic                    aluOverflow;
    logic                    aluZero;
    flagVec                  aluFlags;
    logic [ramAddrWidth-1:0] ramAddr;
    logic [dataWidth-1:0]    ramWriteData;
    logic [dataWidth-1:0]    ramReadData;
    logic                    ramWrite;

    regPortIf #(.dataWidth(dataWidth)) regPort_i ();

    assign aluFlags[flagCarry]    = aluCarry;
    assign aluFlags[flagSign]     = aluSign;
    assign aluFlags[flagOverflow] = aluOverflow;
    assign aluFlags[flagZero]     = aluZero;

    aluUnit #(.dataWidth(dataWidth)) alu_i (
        .opA         (aluA),
        .opB         (aluB),
        .op          (aluOpSel),
        .carryIn     (aluCarryIn),
        .result      (aluResult),
        .carryOut    (aluCarry),
        .signOut     (aluSign),
        .overflowOut (aluOverflow),
        .zeroOut     (aluZero)
    );

    instrDecoder #(.dataWidth(dataWidth), .ramAddrWidth(ramAddrWidth)) decoder_i (
        .clock          (clock),
        .arstN          (arstN),
        .instr          (instr),
        .regLoad        (regLoad),
        .regChoose      (regChoose),
        .regData        (regData),
        .aluResult      (aluResult),
        .aluFlags       (aluFlags),
        .ramReadData    (ramReadData),
        .aluA           (aluA),
        .aluB           (aluB),
        .aluOpSel       (aluOpSel),
        .aluCarryIn     (aluCarryIn),
        .ramAddr        (ramAddr),
        .ramWriteData   (ramWriteData),
        .ramWrite       (ramWrite),
        .flags          (flags),
        .instructionOut (instructionOut),
        .regPort        (regPort_i.ctrl)
    );

    regFile #(.dataWidth(dataWidth)) regs_i (
        .clock   (clock),
        .arstN   (arstN),
        .dbgSel  (dbgSel),
        .dbgData (dbgData),
        .regPort (regPort_i.regs)
    );

    dataRam #(.dataWidth(dataWidth), .ramAddrWidth(ramAddrWidth)) ram_i (
        .clock     (clock),
        .addr      (ramAddr),
        .writeData (ramWriteData),
        .write     (ramWrite),
        .readData  (ramReadData)
    );

endmodule

`default_nettype wire

// File: design/dataRam.sv
// Data RAM with combinational read and write on the rising clock edge
`timescale 1ns/1ns
`default_nettype none

module dataRam #(
    parameter int dataWidth    = 16,
    parameter int ramAddrWidth = 8
) (
    input  logic                    clock,
    input  logic [ramAddrWidth-1:0] addr,
    input  logic [dataWidth-1:0]    writeData,
    input  logic                    write,
    output logic [dataWidth-1:0]    readData
);
    logic [dataWidth-1:0] mem [2**ramAddrWidth];

    assign readData = mem[addr];   // Load completes same cycle

    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= writeData;
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
// Register file: r0-r5, sp and ip with two reads, a debug read, one write and ip stepping
`timescale 1ns/1ns
`default_nettype none

module regFile import procPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  regSel                dbgSel,
    output logic [dataWidth-1:0] dbgData,
    regPortIf.regs               regPort
);
    logic [dataWidth-1:0] regs [regCount];
    logic                 ipWritten;

    assign regPort.rdDataA = regs[regPort.rdSelA];
    assign regPort.rdDataB = regs[regPort.rdSelB];
    assign dbgData         = regs[dbgSel];

    assign ipWritten = regPort.wrEn && (regPort.wrSel == regIp);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (regPort.wrEn) begin
                regs[regPort.wrSel] <= regPort.wrData;
            end
            if (regPort.ipStep && !ipWritten) begin
                regs[regIp] <= regs[regIp] + 1'b1;  // Explicit ip write wins
            end
        end
    end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
// Instruction decoder: field split, condition check, flags, write-back and RAM control
`timescale 1ns/1ns
`default_nettype none

module instrDecoder import procPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int ramAddrWidth = 8
) (
    input  logic                    clock,
    input  logic                    arstN,
    input  instrWord                instr,
    input  logic                    regLoad,
    input  regSel                   regChoose,
    input  logic [dataWidth-1:0]    regData,
    input  logic [dataWidth-1:0]    aluResult,
    input  flagVec                  aluFlags,
    input  logic [dataWidth-1:0]    ramReadData,
    output logic [dataWidth-1:0]    aluA,
    output logic [dataWidth-1:0]    aluB,
    output aluOp                    aluOpSel,
    output logic                    aluCarryIn,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic [dataWidth-1:0]    ramWriteData,
    output logic                    ramWrite,
    output flagVec                  flags,
    output coreInstr                instructionOut,
    regPortIf.ctrl                  regPort
);
    logic    isCore;
    logic    isAlu;
    aluOp    opField;
    condCode condField;
    regSel   dstField;
    regSel   srcField;
    logic    condPass;
    logic    execute;

    assign isCore    = instr[posCore];
    assign isAlu     = instr[posAlu];
    assign opField   = instr[posOpHi:posOpLo];
    assign condField = instr[posCondHi:posCondLo];
    assign dstField  = instr[posDstHi:posDstLo];
    assign srcField  = instr[posSrcHi:posSrcLo];

    assign regPort.rdSelA = dstField;
    assign regPort.rdSelB = srcField;
    assign regPort.ipStep = !regLoad;   // Core words still step ip

    assign aluA         = regPort.rdDataA;
    assign aluB         = regPort.rdDataB;
    assign aluOpSel     = opField;
    assign aluCarryIn   = flags[flagCarry];
    assign ramAddr      = regPort.rdDataB[ramAddrWidth-1:0];
    assign ramWriteData = regPort.rdDataA;

    always_comb begin
        case (condField)
            condEq:  condPass = flags[flagZero];
            condNe:  condPass = !flags[flagZero];
            condGt:  condPass = !flags[flagZero] && (flags[flagSign] == flags[flagOverflow]);
            condLt:  condPass = flags[flagSign] != flags[flagOverflow];
            condGe:  condPass = flags[flagSign] == flags[flagOverflow];
            condLe:  condPass = flags[flagZero] || (flags[flagSign] != flags[flagOverflow]);
            condCs:  condPass = flags[flagCarry];
            condCc:  condPass = !flags[flagCarry];
            condMi:  condPass = flags[flagSign];
            condPl:  condPass = !flags[flagSign];
            condAl:  condPass = 1'b1;
            condNv:  condPass = 1'b0;
            condVs:  condPass = flags[flagOverflow];
            condVc:  condPass = !flags[flagOverflow];
            condHi:  condPass = !flags[flagCarry] && !flags[flagZero];  // Carry is borrow
            condLs:  condPass = flags[flagCarry] || flags[flagZero];
            default: condPass = 1'b0;
        endcase
    end

    assign execute = !regLoad && !isCore && condPass;

    // Write-back source and store enable
    always_comb begin
        regPort.wrEn   = 1'b0;
        regPort.wrSel  = dstField;
        regPort.wrData = aluResult;
        ramWrite       = 1'b0;
        if (regLoad) begin
            regPort.wrEn   = 1'b1;
            regPort.wrSel  = regChoose;
            regPort.wrData = regData;
        end else if (execute) begin
            if (isAlu) begin
                regPort.wrEn = 1'b1;
            end else begin
                case (opField)
                    memLoad: begin
                        regPort.wrEn   = 1'b1;
                        regPort.wrData = ramReadData;
                    end
                    memStore: ramWrite = 1'b1;
                    memMove: begin
                        regPort.wrEn   = 1'b1;
                        regPort.wrData = regPort.rdDataB;
                    end
                    default: regPort.wrEn = 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            flags          <= '0;
            instructionOut <= nopWord;
        end else if (!regLoad) begin
            // Upper 15 bits of a core word go out as is
            instructionOut <= isCore ? instr[posSrcHi:posAlu] : nopWord;
            if (execute && isAlu) begin
                flags <= aluFlags;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/aluUnit.sv
// ALU: arithmetic, logic and single-bit shift operations with carry, sign, overflow, zero
`timescale 1ns/1ns
`default_nettype none

module aluUnit import procPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  aluOp                 op,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] result,
    output logic                 carryOut,
    output logic                 signOut,
    output logic                 overflowOut,
    output logic                 zeroOut
);
    localparam int msb = dataWidth - 1;

    logic [dataWidth:0] sum;    // Extra bit holds carry or borrow
    logic               cin;

    assign cin = carryIn && ((op == opAdc) || (op == opSbc));

    always_comb begin
        sum         = '0;
        result      = opB;      // Unused codes pass the second operand
        carryOut    = 1'b0;
        overflowOut = 1'b0;
        case (op)
            opAdd, opAdc: begin
                sum         = {1'b0, opA} + {1'b0, opB} + {{dataWidth{1'b0}}, cin};
                result      = sum[msb:0];
                carryOut    = sum[dataWidth];
                overflowOut = (opA[msb] == opB[msb]) && (result[msb] != opA[msb]);
            end
            opSub, opSbc: begin
                sum         = {1'b0, opA} - {1'b0, opB} - {{dataWidth{1'b0}}, cin};
                result      = sum[msb:0];
                carryOut    = sum[dataWidth];   // Borrow
                overflowOut = (opA[msb] != opB[msb]) && (result[msb] != opA[msb]);
            end
            opAnd: result = opA & opB;
            opOr:  result = opA | opB;
            opXor: result = opA ^ opB;
            opNot: result = ~opA;
            opShl: begin
                result   = {opA[msb-1:0], 1'b0};
                carryOut = opA[msb];
            end
            opShr: begin
                result   = {1'b0, opA[msb:1]};
                carryOut = opA[0];
            end
            opSar: begin
                result   = {opA[msb], opA[msb:1]};  // Sign kept
                carryOut = opA[0];
            end
            default: result = opB;
        endcase
    end

    assign signOut = result[msb];
    assign zeroOut = (result == '0);

endmodule

`default_nettype wire

// File: design/regPortIf.sv
// Register file port bundle: two read ports, one write port and ip stepping
`timescale 1ns/1ns
`default_nettype none

interface regPortIf import procPkg::*; #(
    parameter int dataWidth = 16
);
    regSel                rdSelA;   // Always dst
    regSel                rdSelB;   // Always src
    logic [dataWidth-1:0] rdDataA;
    logic [dataWidth-1:0] rdDataB;
    logic                 wrEn;
    regSel                wrSel;
    logic [dataWidth-1:0] wrData;
    logic                 ipStep;

    modport ctrl (
        output rdSelA, rdSelB, wrEn, wrSel, wrData, ipStep,
        input  rdDataA, rdDataB
    );

    modport regs (
        input  rdSelA, rdSelB, wrEn, wrSel, wrData, ipStep,
        output rdDataA, rdDataB
    );
endinterface

`default_nettype wire

// File: design/procPkg.sv
// Processor package: field widths, instruction layout, opcode, condition and flag constants
`default_nettype none

package procPkg;

    typedef logic [2:0]  regSel;
    typedef logic [3:0]  aluOp;
    typedef logic [3:0]  condCode;
    typedef logic [3:0]  flagVec;
    typedef logic [15:0] instrWord;
    typedef logic [14:0] coreInstr;

    localparam int    regCount = 8;
    localparam regSel regIp    = 3'd7;     // Instruction pointer slot

    // Flag bit positions
    localparam int flagCarry    = 0;
    localparam int flagSign     = 1;
    localparam int flagOverflow = 2;
    localparam int flagZero     = 3;

    // Instruction word fields
    localparam int posCore   = 0;
    localparam int posAlu    = 1;
    localparam int posOpLo   = 2;
    localparam int posOpHi   = 5;
    localparam int posCondLo = 6;
    localparam int posCondHi = 9;
    localparam int posDstLo  = 10;
    localparam int posDstHi  = 12;
    localparam int posSrcLo  = 13;
    localparam int posSrcHi  = 15;

    localparam aluOp opAdd = 4'd0;
    localparam aluOp opAdc = 4'd1;
    localparam aluOp opSub = 4'd2;
    localparam aluOp opSbc = 4'd3;
    localparam aluOp opAnd = 4'd4;
    localparam aluOp opOr  = 4'd5;
    localparam aluOp opXor = 4'd6;
    localparam aluOp opNot = 4'd7;
    localparam aluOp opShl = 4'd8;
    localparam aluOp opShr = 4'd9;
    localparam aluOp opSar = 4'd10;

    // Memory ops share the op field when the ALU bit is clear
    localparam aluOp memLoad  = 4'd0;
    localparam aluOp memStore = 4'd1;
    localparam aluOp memMove  = 4'd2;

    localparam condCode condEq = 4'd0;
    localparam condCode condNe = 4'd1;
    localparam condCode condGt = 4'd2;
    localparam condCode condLt = 4'd3;
    localparam condCode condGe = 4'd4;
    localparam condCode condLe = 4'd5;
    localparam condCode condCs = 4'd6;
    localparam condCode condCc = 4'd7;
    localparam condCode condMi = 4'd8;
    localparam condCode condPl = 4'd9;
    localparam condCode condAl = 4'd10;
    localparam condCode condNv = 4'd11;
    localparam condCode condVs = 4'd12;
    localparam condCode condVc = 4'd13;
    localparam condCode condHi = 4'd14;
    localparam condCode condLs = 4'd15;

    // addnv r0,r0 with the core bit dropped
    localparam coreInstr nopWord = 15'b000_000_1011_0000_1;

endpackage

`default_nettype wire
